// File: hw/marble_pkg.sv
// ----------------------------------------
// Board core shared definitions
// ----------------------------------------

package marble_pkg;

	// One GMII beat, en reads as dv on the receive side
	typedef struct packed {
		logic [7:0] data;
		logic       en;
		logic       er;
	} gmii_t;

	// One RGMII beat split into its two clock edges
	typedef struct packed {
		logic [3:0] rise_d;
		logic       rise_ctl;
		logic [3:0] fall_d;
		logic       fall_ctl;
	} rgmii_pair_t;

	// Configuration byte written by the microcontroller
	typedef struct packed {
		logic [4:0] spare;
		logic       loopback_enable;
		logic       vcxo_off;
		logic       tmds_enable;
	} ext_config_t;

	// SPI mailbox opcodes, other values are ignored
	typedef enum logic [7:0] {
		OP_WRITE_CONFIG = 8'h01,
		OP_READ_FRAMES  = 8'h02,
		OP_READ_ERRORS  = 8'h03
	} spi_op_t;

	// TMDS pattern generator states
	typedef enum logic {
		IDLE,
		RUN
	} tmds_state_t;

	// Loopback on, TMDS off, VCXO running
	localparam logic [7:0] MISC_CONFIG_DEFAULT = 8'h04;

	// PHY held in reset this many cycles
	localparam int PHY_RESET_CYCLES = 16;
	localparam int PHY_RESET_W      = $clog2(PHY_RESET_CYCLES);

	// Opcode byte plus data byte
	localparam logic [4:0] SPI_FRAME_BITS = 5'd16;

	// Lane words for the TMDS pattern
	localparam logic [9:0] TMDS_WORD_CH  = 10'b1101010100;
	localparam logic [9:0] TMDS_WORD_CLK = 10'b1111100000;

endpackage

// File: hw/gmii_to_rgmii.sv
// ----------------------------------------
// RGMII to GMII conversion
// ----------------------------------------
`timescale 1ns/1ps

module gmii_to_rgmii
	import marble_pkg::*;
(
	input  logic        tx_clk,
	input  logic        rst_n,
	input  rgmii_pair_t rgmii_rx,
	output rgmii_pair_t rgmii_tx,
	input  gmii_t       gmii_tx,
	output gmii_t       gmii_rx
);

	// Transmit direction
	// Low nibble on the rising edge, high nibble on the falling edge
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			rgmii_tx <= '0;
		end else begin
			rgmii_tx.rise_d   <= gmii_tx.data[3:0];
			rgmii_tx.fall_d   <= gmii_tx.data[7:4];
			rgmii_tx.rise_ctl <= gmii_tx.en;
			// Error rides on the falling edge as en xor er
			rgmii_tx.fall_ctl <= gmii_tx.en ^ gmii_tx.er;
		end
	end

	// Receive direction
	// Assumes the PHY clock is phase aligned to tx_clk
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			gmii_rx.en <= 1'b0;
			gmii_rx.er <= 1'b0;
		end else begin
			// dv comes straight from the rising edge control
			gmii_rx.en <= rgmii_rx.rise_ctl;
			// Control bits differing across edges flags an error
			gmii_rx.er <= rgmii_rx.rise_ctl ^ rgmii_rx.fall_ctl;
		end
	end

	// Receive byte, no reset on the data path
	always_ff @(posedge tx_clk) begin
		// High nibble from the falling edge
		gmii_rx.data <= {rgmii_rx.fall_d, rgmii_rx.rise_d};
	end

	// Pins idle one cycle after any reset cycle
	a_tx_idle_after_reset: assert property (
		@(posedge tx_clk) !rst_n |=> (rgmii_tx == '0)
	) else $error("rgmii_tx not idle after reset");

endmodule

// File: hw/frame_loopback.sv
// ----------------------------------------
// GMII frame loopback and counters
// ----------------------------------------
`timescale 1ns/1ps

module frame_loopback
	import marble_pkg::*;
(
	input  logic       tx_clk,
	input  logic       rst_n,
	input  logic       loopback_enable,
	input  gmii_t      gmii_rx,
	output gmii_t      gmii_tx,
	input  logic       err_clr,
	output logic [7:0] frame_count,
	output logic [7:0] error_count
);

	// Previous dv, for the end-of-frame edge
	logic dv_d;
	// Error seen somewhere in the current frame
	logic err_seen;
	logic frame_end;

	assign frame_end = dv_d & ~gmii_rx.en;

	// Echo path, one register stage
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			gmii_tx <= '0;
		end else if (loopback_enable) begin
			gmii_tx <= gmii_rx;
		end else begin
			// Idle line when loopback is off
			gmii_tx <= '0;
		end
	end

	// Frame tracking
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			dv_d     <= 1'b0;
			err_seen <= 1'b0;
		end else begin
			dv_d <= gmii_rx.en;
			if (frame_end) begin
				err_seen <= 1'b0;
			end else if (gmii_rx.en && gmii_rx.er) begin
				err_seen <= 1'b1;
			end
		end
	end

	// Counters wrap at 8 bits
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			frame_count <= '0;
			error_count <= '0;
		end else begin
			if (frame_end && !err_seen) begin
				frame_count <= frame_count + 8'd1;
			end
			// Clear from the mailbox wins over a new error
			if (err_clr) begin
				error_count <= '0;
			end else if (frame_end && err_seen) begin
				error_count <= error_count + 8'd1;
			end
		end
	end

	// Nothing transmitted the cycle after loopback drops
	a_no_tx_when_off: assert property (
		@(posedge tx_clk) disable iff (!rst_n) !loopback_enable |=> !gmii_tx.en
	) else $error("gmii_tx active with loopback off");

endmodule

// File: hw/mmc_spi_port.sv
// ----------------------------------------
// Microcontroller SPI mailbox
// ----------------------------------------
`timescale 1ns/1ps

module mmc_spi_port
	import marble_pkg::*;
(
	input  logic       tx_clk,
	input  logic       rst_n,
	input  logic       sclk,
	input  logic       csb,
	input  logic       mosi,
	output logic       miso,
	input  logic [7:0] frame_count,
	input  logic [7:0] error_count,
	output logic       cfg_we,
	output logic [7:0] cfg_data,
	output logic       err_clr
);

	logic [1:0] sclk_s, csb_s, mosi_s;
	logic       sclk_d, csb_d;
	logic       sclk_rise, sclk_fall, csb_rise;
	logic [4:0] bit_cnt;
	logic [6:0] shift_in;
	logic [7:0] rx_byte;
	logic [7:0] tx_shift;
	logic       in_data_phase;
	spi_op_t    opcode;

	// Two flop synchronizers plus one stage for edges
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			sclk_s <= '0;
			csb_s  <= '1;
			mosi_s <= '0;
			sclk_d <= 1'b0;
			csb_d  <= 1'b1;
		end else begin
			sclk_s <= {sclk_s[0], sclk};
			csb_s  <= {csb_s[0], csb};
			mosi_s <= {mosi_s[0], mosi};
			sclk_d <= sclk_s[1];
			csb_d  <= csb_s[1];
		end
	end

	assign sclk_rise = sclk_s[1] & ~sclk_d;
	assign sclk_fall = ~sclk_s[1] & sclk_d;
	assign csb_rise  = csb_s[1] & ~csb_d;
	// Byte completed by the bit being sampled now
	assign rx_byte   = {shift_in, mosi_s[1]};
	// Bits 8 to 15 carry the reply
	assign in_data_phase = (bit_cnt >= 5'd8) && (bit_cnt < SPI_FRAME_BITS);

	// Frame control
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			opcode  <= spi_op_t'(8'h00);
			miso    <= 1'b0;
			cfg_we  <= 1'b0;
			err_clr <= 1'b0;
		end else begin
			cfg_we  <= 1'b0;
			err_clr <= 1'b0;
			if (csb_s[1]) begin
				// Only a full read-errors frame clears the count
				if (csb_rise && bit_cnt == SPI_FRAME_BITS && opcode == OP_READ_ERRORS) begin
					err_clr <= 1'b1;
				end
				bit_cnt <= '0;
				miso    <= 1'b0;
			end else begin
				// Bits past the 16th are ignored
				if (sclk_rise && bit_cnt != SPI_FRAME_BITS) begin
					bit_cnt <= bit_cnt + 5'd1;
					if (bit_cnt == 5'd7) begin
						opcode <= spi_op_t'(rx_byte);
					end
					if (bit_cnt == SPI_FRAME_BITS - 5'd1 && opcode == OP_WRITE_CONFIG) begin
						cfg_we <= 1'b1;
					end
				end
				// Reply changes on the falling edge, MSB first
				if (sclk_fall) begin
					miso <= in_data_phase ? tx_shift[7] : 1'b0;
				end
			end
		end
	end

	// Shift registers
	always_ff @(posedge tx_clk) begin
		if (sclk_rise) begin
			shift_in <= rx_byte[6:0];
		end
		// Counter latched as the opcode byte completes
		if (!csb_s[1] && sclk_rise && bit_cnt == 5'd7) begin
			case (spi_op_t'(rx_byte))
				OP_READ_FRAMES: tx_shift <= frame_count;
				OP_READ_ERRORS: tx_shift <= error_count;
				default:        tx_shift <= 8'h00;
			endcase
		end else if (sclk_fall && in_data_phase) begin
			tx_shift <= {tx_shift[6:0], 1'b0};
		end
		if (sclk_rise && bit_cnt == SPI_FRAME_BITS - 5'd1) begin
			cfg_data <= rx_byte;
		end
	end

	// A write frame and a clear never coincide
	a_we_clr_exclusive: assert property (
		@(posedge tx_clk) disable iff (!rst_n) !(cfg_we && err_clr)
	) else $error("cfg_we and err_clr both high");

endmodule

// File: hw/marble_base.sv
// ----------------------------------------
// Portable board core
// ----------------------------------------
`timescale 1ns/1ps

module marble_base
	import marble_pkg::*;
(
	input  logic        tx_clk,
	input  logic        rst_n,
	input  gmii_t       gmii_rx,
	output gmii_t       gmii_tx,
	input  logic        sclk,
	input  logic        csb,
	input  logic        mosi,
	output logic        miso,
	output logic        mmc_int,
	output logic        phy_rstn,
	output ext_config_t ext_config,
	output logic [7:0]  leds
);

	logic [7:0]             frame_count;
	logic [7:0]             error_count;
	logic                   cfg_we;
	logic [7:0]             cfg_data;
	logic                   err_clr;
	logic [PHY_RESET_W-1:0] phy_cnt;

	// Config register, new value visible one cycle after the strobe
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			ext_config <= ext_config_t'(MISC_CONFIG_DEFAULT);
		end else if (cfg_we) begin
			ext_config <= ext_config_t'(cfg_data);
		end
	end

	// PHY reset timer
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			phy_cnt  <= '0;
			phy_rstn <= 1'b0;
		end else if (!phy_rstn) begin
			if (phy_cnt == PHY_RESET_W'(PHY_RESET_CYCLES - 1)) begin
				phy_rstn <= 1'b1;
			end else begin
				phy_cnt <= phy_cnt + 1'b1;
			end
		end
	end

	// Interrupt holds while errors are pending
	assign mmc_int = |error_count;
	assign leds    = frame_count;

	frame_loopback u_frame_loopback (
		.tx_clk          (tx_clk),
		.rst_n           (rst_n),
		.loopback_enable (ext_config.loopback_enable),
		.gmii_rx         (gmii_rx),
		.gmii_tx         (gmii_tx),
		.err_clr         (err_clr),
		.frame_count     (frame_count),
		.error_count     (error_count)
	);

	mmc_spi_port u_mmc_spi_port (
		.tx_clk      (tx_clk),
		.rst_n       (rst_n),
		.sclk        (sclk),
		.csb         (csb),
		.mosi        (mosi),
		.miso        (miso),
		.frame_count (frame_count),
		.error_count (error_count),
		.cfg_we      (cfg_we),
		.cfg_data    (cfg_data),
		.err_clr     (err_clr)
	);

endmodule

// File: hw/tmds_test.sv
// ----------------------------------------
// TMDS test pattern
// ----------------------------------------
`timescale 1ns/1ps

module tmds_test
	import marble_pkg::*;
(
	input  logic       tx_clk,
	input  logic       rst_n,
	input  logic       enable,
	output logic [3:0] tmds_p,
	output logic [3:0] tmds_n
);

	tmds_state_t state;
	// Lanes 0 to 2 data, lane 3 clock
	logic [3:0][9:0] lane_sr;

	// State machine and output stage
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			state  <= IDLE;
			tmds_p <= '0;
			tmds_n <= '1;
		end else begin
			case (state)
				IDLE: if (enable) state <= RUN;
				RUN:  if (!enable) state <= IDLE;
				default: state <= IDLE;
			endcase
			for (int i = 0; i < 4; i++) begin
				tmds_p[i] <= (state == RUN) ? lane_sr[i][9] : 1'b0;
				tmds_n[i] <= (state == RUN) ? ~lane_sr[i][9] : 1'b1;
			end
		end
	end

	// Lane words, loaded on entry and rotated while running
	always_ff @(posedge tx_clk) begin
		for (int i = 0; i < 4; i++) begin
			if (state == IDLE) begin
				lane_sr[i] <= (i == 3) ? TMDS_WORD_CLK : TMDS_WORD_CH;
			end else begin
				lane_sr[i] <= {lane_sr[i][8:0], lane_sr[i][9]};
			end
		end
	end

	// Differential pair stays complementary
	a_tmds_complement: assert property (
		@(posedge tx_clk) disable iff (!rst_n) tmds_n == ~tmds_p
	) else $error("tmds_n not complement of tmds_p");

endmodule

// File: hw/marble_top.sv
// ----------------------------------------
// Board test build top
// ----------------------------------------
`timescale 1ns/1ps

module marble_top
	import marble_pkg::*;
(
	input  logic        tx_clk,
	input  logic        rst_n,
	input  rgmii_pair_t rgmii_rx,
	output rgmii_pair_t rgmii_tx,
	output logic        phy_rstn,
	input  logic        sclk,
	input  logic        csb,
	input  logic        mosi,
	output logic        miso,
	output logic        mmc_int,
	output logic        vcxo_en,
	output logic [3:0]  tmds_p,
	output logic [3:0]  tmds_n,
	output logic        ld16,
	output logic        ld17,
	output logic [7:0]  pmod1
);

	gmii_t       gmii_rx;
	gmii_t       gmii_tx;
	ext_config_t ext_config;
	logic [7:0]  leds;

	// DDR conversion
	gmii_to_rgmii u_gmii_to_rgmii (
		.tx_clk   (tx_clk),
		.rst_n    (rst_n),
		.rgmii_rx (rgmii_rx),
		.rgmii_tx (rgmii_tx),
		.gmii_tx  (gmii_tx),
		.gmii_rx  (gmii_rx)
	);

	marble_base u_marble_base (
		.tx_clk (tx_clk), .rst_n (rst_n),
		.gmii_rx (gmii_rx), .gmii_tx (gmii_tx),
		.sclk (sclk), .csb (csb), .mosi (mosi), .miso (miso),
		.mmc_int (mmc_int), .phy_rstn (phy_rstn),
		.ext_config (ext_config), .leds (leds)
	);

	tmds_test u_tmds_test (
		.tx_clk (tx_clk), .rst_n (rst_n), .enable (ext_config.tmds_enable),
		.tmds_p (tmds_p), .tmds_n (tmds_n)
	);

	// Pmod and the two LEDs show the frame count
	assign pmod1 = leds;
	assign ld16  = leds[0];
	assign ld17  = leds[1];
	// Config can stop the VCXO
	assign vcxo_en = ~ext_config.vcxo_off;

endmodule

// File: bench/marble_top_tb.sv
// ----------------------------------------
// Board core testbench
// ----------------------------------------
`timescale 1ns/1ps

module marble_top_tb
	import marble_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int LOOP_DELAY = 3;
	localparam int FRAME_GAP  = 12;
	localparam int FRAME_MAX  = 48;
	localparam int SPI_HALF   = 6;
	localparam int N_CLEAN    = 6;
	localparam int N_ERROR    = 2;
	localparam int N_OFF      = 2;
	localparam int N_SPI      = 7;
	// Lane 3 index where the word first steps from 1 to 0
	localparam int CLK_FALL_PHASE = 5;
	localparam int FRAME_CYCLES   = FRAME_MAX + FRAME_GAP + 2;
	localparam int SPI_CYCLES     = 16 * (2 * SPI_HALF + 2) + 3 * SPI_HALF;
	localparam int TEST_CYCLES    = (N_CLEAN + N_ERROR + N_OFF + 1) * FRAME_CYCLES
		+ N_SPI * SPI_CYCLES + 200;
	// Twice the stimulus length as margin
	localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

	logic        tx_clk;
	logic        rst_n;
	rgmii_pair_t rgmii_rx;
	rgmii_pair_t rgmii_tx;
	logic        phy_rstn;
	logic        sclk;
	logic        csb;
	logic        mosi;
	logic        miso;
	logic        mmc_int;
	logic        vcxo_en;
	logic [3:0]  tmds_p;
	logic [3:0]  tmds_n;
	logic        ld16;
	logic        ld17;
	logic [7:0]  pmod1;

	// Reference model state
	integer      seed;
	gmii_t       sent_beat;
	ext_config_t model_cfg;
	logic [7:0]  model_frames;
	logic [7:0]  model_errors;
	logic        mon_en;
	rgmii_pair_t exp_q[$];
	rgmii_pair_t exp_pair;

	marble_top u_marble_top (
		.tx_clk   (tx_clk),
		.rst_n    (rst_n),
		.rgmii_rx (rgmii_rx),
		.rgmii_tx (rgmii_tx),
		.phy_rstn (phy_rstn),
		.sclk     (sclk),
		.csb      (csb),
		.mosi     (mosi),
		.miso     (miso),
		.mmc_int  (mmc_int),
		.vcxo_en  (vcxo_en),
		.tmds_p   (tmds_p),
		.tmds_n   (tmds_n),
		.ld16     (ld16),
		.ld17     (ld17),
		.pmod1    (pmod1)
	);

	initial tx_clk = 1'b0;
	always #(CLK_PERIOD / 2) tx_clk = ~tx_clk;

	// Expected RGMII pair for one GMII beat
	function automatic rgmii_pair_t encode_pair(input logic [7:0] data, input logic en,
		input logic er);
		rgmii_pair_t p;
		p.rise_d   = data[3:0];
		p.rise_ctl = en;
		p.fall_d   = data[7:4];
		p.fall_ctl = en ^ er;
		return p;
	endfunction

	task automatic stop_with_failure();
		$display(">>> FAIL");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic report_failure(input string what);
		$display("error at %0t: %s", $time, what);
		stop_with_failure();
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, actual,
				expected);
			stop_with_failure();
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge tx_clk);
	endtask

	// One frame of random bytes, er set on err_beat unless it is negative
	task automatic send_frame(input int len, input int err_beat);
		gmii_t beat;
		for (int i = 0; i < len; i++) begin
			beat.data = 8'($random(seed));
			beat.en   = 1'b1;
			beat.er   = (i == err_beat);
			@(posedge tx_clk);
			rgmii_rx  <= encode_pair(beat.data, beat.en, beat.er);
			sent_beat <= beat;
		end
		@(posedge tx_clk);
		rgmii_rx  <= '0;
		sent_beat <= '0;
		wait_cycles(FRAME_GAP);
		if (err_beat < 0) begin
			model_frames = model_frames + 8'd1;
		end else begin
			model_errors = model_errors + 8'd1;
		end
		@(negedge tx_clk);
		check_value(pmod1, model_frames, "pmod1 frame count");
		check_value({ld17, ld16}, model_frames[1:0], "ld17 and ld16");
		check_value(mmc_int, model_errors != 8'd0, "mmc_int level");
	endtask

	// Mode 0 transfer, nbits below 16 ends the frame early
	task automatic spi_frame(input logic [15:0] word, input int nbits, output logic [7:0] rx);
		logic [7:0] r;
		r = '0;
		@(posedge tx_clk);
		csb  <= 1'b0;
		mosi <= word[15];
		for (int i = 0; i < nbits; i++) begin
			wait_cycles(SPI_HALF);
			sclk <= 1'b1;
			wait_cycles(SPI_HALF);
			// Reply bits are stable through the high phase
			if (i >= 8) begin
				@(negedge tx_clk);
				r = {r[6:0], miso};
				@(posedge tx_clk);
			end
			sclk <= 1'b0;
			mosi <= (i < 15) ? word[14 - i] : 1'b0;
		end
		wait_cycles(SPI_HALF);
		csb <= 1'b1;
		wait_cycles(SPI_HALF);
		rx = r;
	endtask

	task automatic write_config(input logic [7:0] value);
		logic [7:0] got;
		spi_frame({OP_WRITE_CONFIG, value}, 16, got);
		model_cfg = ext_config_t'(value);
		check_value(got, 8'h00, "miso during config write");
		@(negedge tx_clk);
		check_value(vcxo_en, !model_cfg.vcxo_off, "vcxo_en after config write");
	endtask

	task automatic read_counter(input spi_op_t op, input logic [7:0] expected,
		input string what);
		logic [7:0] got;
		spi_frame({op, 8'h00}, 16, got);
		check_value(got, expected, what);
	endtask

	// Loopback compare, rgmii_tx trails the driven beat by three cycles
	always @(negedge tx_clk) begin
		if (mon_en) begin
			if (model_cfg.loopback_enable) begin
				exp_q.push_back(encode_pair(sent_beat.data, sent_beat.en, sent_beat.er));
			end else begin
				exp_q.push_back('0);
			end
			if (exp_q.size() > LOOP_DELAY) begin
				exp_pair = exp_q.pop_front();
				check_value(rgmii_tx, exp_pair, "rgmii_tx against delayed rx beat");
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_failure("timeout, the tests did not finish in the allowed time");
	end

	initial begin
		int         len;
		int         err_beat;
		int         phase;
		logic [7:0] reply;
		logic       prev_bit;
		logic       found;
		seed         = 11;
		rst_n        = 1'b0;
		rgmii_rx     = '0;
		sent_beat    = '0;
		sclk         = 1'b0;
		csb          = 1'b1;
		mosi         = 1'b0;
		mon_en       = 1'b0;
		model_cfg    = ext_config_t'(MISC_CONFIG_DEFAULT);
		model_frames = '0;
		model_errors = '0;

		// Reset for three edges
		wait_cycles(3);
		rst_n <= 1'b1;
		@(negedge tx_clk);
		check_value(rgmii_tx, 0, "rgmii_tx after reset");
		check_value(miso, 1'b0, "miso after reset");
		check_value(mmc_int, 1'b0, "mmc_int after reset");
		check_value(tmds_p, 4'h0, "tmds_p after reset");
		check_value(tmds_n, 4'hf, "tmds_n after reset");
		check_value(vcxo_en, 1'b1, "vcxo_en after reset");
		check_value(phy_rstn, 1'b0, "phy_rstn in reset");
		for (int k = 1; k <= PHY_RESET_CYCLES; k++) begin
			@(negedge tx_clk);
			check_value(phy_rstn, k == PHY_RESET_CYCLES, "phy_rstn release timing");
		end
		@(posedge tx_clk);
		mon_en = 1'b1;

		// Clean frames through the loopback
		for (int f = 0; f < N_CLEAN; f++) begin
			len = 8 + ($unsigned($random(seed)) % 40);
			send_frame(len, -1);
		end
		read_counter(OP_READ_FRAMES, model_frames, "frame count over SPI");

		// Frames with one errored beat
		for (int f = 0; f < N_ERROR; f++) begin
			len      = 8 + ($unsigned($random(seed)) % 40);
			err_beat = $unsigned($random(seed)) % len;
			send_frame(len, err_beat);
		end
		// Cut-short read must not clear
		spi_frame({OP_READ_ERRORS, 8'h00}, 12, reply);
		@(negedge tx_clk);
		check_value(mmc_int, 1'b1, "mmc_int after short read frame");
		read_counter(OP_READ_ERRORS, model_errors, "error count over SPI");
		model_errors = '0;
		@(negedge tx_clk);
		check_value(mmc_int, 1'b0, "mmc_int after error clear");

		// Cut-short write leaves loopback on and the VCXO running
		spi_frame({OP_WRITE_CONFIG, 8'h02}, 12, reply);
		@(negedge tx_clk);
		check_value(vcxo_en, 1'b1, "vcxo_en after short write frame");
		len = 8 + ($unsigned($random(seed)) % 40);
		send_frame(len, -1);

		// Loopback off and VCXO stopped
		write_config(8'h02);
		for (int f = 0; f < N_OFF; f++) begin
			len = 8 + ($unsigned($random(seed)) % 40);
			send_frame(len, -1);
		end
		read_counter(OP_READ_FRAMES, model_frames, "frame count with loopback off");

		// TMDS pattern, phase taken from the clock lane
		write_config(8'h01);
		@(negedge tx_clk);
		prev_bit = tmds_p[3];
		found    = 1'b0;
		for (int n = 0; n < 40 && !found; n++) begin
			@(negedge tx_clk);
			if (prev_bit && !tmds_p[3]) begin
				found = 1'b1;
			end else begin
				prev_bit = tmds_p[3];
			end
		end
		if (!found) begin
			report_failure("TMDS clock lane never stepped from 1 to 0");
		end
		phase = CLK_FALL_PHASE;
		for (int n = 0; n < 20; n++) begin
			check_value(tmds_p, {TMDS_WORD_CLK[9 - phase], {3{TMDS_WORD_CH[9 - phase]}}},
				"tmds_p lane pattern");
			check_value(tmds_p ^ tmds_n, 4'hf, "tmds_n complement of tmds_p");
			@(negedge tx_clk);
			phase = (phase + 1) % 10;
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: src.f
hw/marble_pkg.sv
hw/gmii_to_rgmii.sv
hw/frame_loopback.sv
hw/mmc_spi_port.sv
hw/marble_base.sv
hw/tmds_test.sv
hw/marble_top.sv
bench/marble_top_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := marble_top_tb
FILELIST   := src.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
PASS_MSG   := >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
